//--- logic/audio_cfg.svh
`ifndef AUDIO_CFG_SVH
`define AUDIO_CFG_SVH

// i2s microphone timing

// audio_clk cycles per bit clock period
`define I2S_CLK_DIV 32

// bit clocks per slot, two slots per frame
`define I2S_SLOT_BITS 32

// tone generator timing

// audio_clk cycles between tone steps, about 24 kHz
`define TONE_TRIG_DIV 4096

// phase steps per trigger, 2^32 * f / 24000
`define PHASE_INCR_750 32'h0800_0000
`define PHASE_INCR_440 32'h04B1_7E4B

`endif

//--- logic/audio_types_pkg.sv
package audio_types_pkg;

  // word and byte widths of the datapath
  localparam int SAMPLE_W = 16;
  localparam int TONE_W = 8;

  // phase accumulator width for the tone generators
  localparam int PHASE_W = 32;

  // one signed pcm sample
  typedef logic signed [SAMPLE_W-1:0] sample_t;

  // one sine amplitude
  typedef logic signed [TONE_W-1:0] tone_t;

  // tone phase, top bits address the sine table
  typedef logic [PHASE_W-1:0] phase_t;

  // sample plus a one-cycle strobe
  typedef struct packed {
    logic    valid;
    sample_t data;
  } mic_sample_t;

endpackage

//--- logic/board_ctrl_pkg.sv
package board_ctrl_pkg;

  // playback source for the speakers and the level monitor
  typedef enum logic [1:0] {
    SRC_SILENT    = 2'd0,
    SRC_TONE      = 2'd1,
    SRC_MIC       = 2'd2,
    SRC_MIC_DECIM = 2'd3
  } source_sel_e;

  // switch settings after decode
  typedef struct packed {
    source_sel_e source;
    // 1 picks 750 Hz, 0 picks 440 Hz
    logic        tone_750;
    logic        spk_l_en;
    logic        spk_r_en;
  } board_ctrl_t;

endpackage

//--- logic/i2s_mic_receiver.sv
`timescale 1ns/1ns

`include "audio_cfg.svh"

module i2s_mic_receiver (
  input  logic                        audio_clk,
  input  logic                        rst,
  input  logic                        mic_data,
  output logic                        mic_bclk,
  output logic                        mic_ws,
  output audio_types_pkg::mic_sample_t mic_full,
  output audio_types_pkg::mic_sample_t mic_decim
);

  import audio_types_pkg::*;

  localparam int HALF_DIV = `I2S_CLK_DIV / 2;
  localparam int DIV_W = $clog2(`I2S_CLK_DIV);
  localparam int FRAME_BITS = 2 * `I2S_SLOT_BITS;
  localparam int BIT_W = $clog2(FRAME_BITS);
  localparam int SAMPLE_BITS = $bits(sample_t);

  logic [DIV_W-1:0] div_cnt;
  logic [BIT_W-1:0] bit_idx;
  logic [BIT_W-1:0] next_bit;
  logic             bit_end;
  logic             bclk_rise;
  logic             in_sample;
  sample_t          shift_q;
  logic             full_stb;
  logic             decim_phase;

  // bit clock period ends here, falling edge of mic_bclk
  assign bit_end = (div_cnt == DIV_W'(`I2S_CLK_DIV - 1));
  assign bclk_rise = (div_cnt == DIV_W'(HALF_DIV - 1));
  assign next_bit = (bit_idx == BIT_W'(FRAME_BITS - 1)) ? '0 : bit_idx + 1'b1;

  // one bit of i2s delay, then 16 bits MSB first in the left slot
  assign in_sample = (bit_idx >= BIT_W'(1)) && (bit_idx <= BIT_W'(SAMPLE_BITS));

  // bit and word clock generation
  always_ff @(posedge audio_clk) begin
    if (rst) begin
      div_cnt  <= '0;
      bit_idx  <= '0;
      mic_bclk <= 1'b0;
      mic_ws   <= 1'b0;
    end else begin
      if (bit_end) begin
        div_cnt  <= '0;
        bit_idx  <= next_bit;
        mic_bclk <= 1'b0;
        // right slot is the upper half of the frame
        mic_ws   <= (next_bit >= BIT_W'(`I2S_SLOT_BITS));
      end else begin
        div_cnt <= div_cnt + 1'b1;
        if (bclk_rise) begin
          mic_bclk <= 1'b1;
        end
      end
    end
  end

  // left slot capture on rising bit clock
  always_ff @(posedge audio_clk) begin
    if (bclk_rise && in_sample) begin
      shift_q <= {shift_q[SAMPLE_BITS-2:0], mic_data};
    end
  end

  // strobe once the last data bit is in
  always_ff @(posedge audio_clk) begin
    if (rst) begin
      full_stb    <= 1'b0;
      decim_phase <= 1'b0;
    end else begin
      full_stb <= bclk_rise && (bit_idx == BIT_W'(SAMPLE_BITS));
      if (full_stb) begin
        decim_phase <= ~decim_phase;
      end
    end
  end

  assign mic_full.valid = full_stb;
  assign mic_full.data = shift_q;

  // every second frame, starting with the second
  assign mic_decim.valid = full_stb & decim_phase;
  assign mic_decim.data = shift_q;

endmodule

//--- logic/tone_source.sv
`timescale 1ns/1ns

`include "audio_cfg.svh"

module tone_source (
  input  logic                   audio_clk,
  input  logic                   rst,
  output audio_types_pkg::tone_t tone_a,
  output audio_types_pkg::tone_t tone_b
);

  import audio_types_pkg::*;

  localparam int TRIG_W = $clog2(`TONE_TRIG_DIV);
  localparam int LUT_MSB = PHASE_W - 1;
  localparam int LUT_LSB = PHASE_W - 6;

  // round(127 * sin(2*pi*k/64))
  localparam tone_t SINE_LUT [64] = '{
    8'sd0,    8'sd12,   8'sd25,   8'sd37,   8'sd49,   8'sd60,   8'sd71,   8'sd81,
    8'sd90,   8'sd98,   8'sd106,  8'sd112,  8'sd117,  8'sd122,  8'sd125,  8'sd126,
    8'sd127,  8'sd126,  8'sd125,  8'sd122,  8'sd117,  8'sd112,  8'sd106,  8'sd98,
    8'sd90,   8'sd81,   8'sd71,   8'sd60,   8'sd49,   8'sd37,   8'sd25,   8'sd12,
    8'sd0,    -8'sd12,  -8'sd25,  -8'sd37,  -8'sd49,  -8'sd60,  -8'sd71,  -8'sd81,
    -8'sd90,  -8'sd98,  -8'sd106, -8'sd112, -8'sd117, -8'sd122, -8'sd125, -8'sd126,
    -8'sd127, -8'sd126, -8'sd125, -8'sd122, -8'sd117, -8'sd112, -8'sd106, -8'sd98,
    -8'sd90,  -8'sd81,  -8'sd71,  -8'sd60,  -8'sd49,  -8'sd37,  -8'sd25,  -8'sd12
  };

  logic [TRIG_W-1:0] trig_cnt;
  logic              trig;
  phase_t            phase_a;
  phase_t            phase_b;

  // fires on counter wrap
  assign trig = (trig_cnt == TRIG_W'(`TONE_TRIG_DIV - 1));

  always_ff @(posedge audio_clk) begin
    if (rst) begin
      trig_cnt <= '0;
    end else if (trig) begin
      trig_cnt <= '0;
    end else begin
      trig_cnt <= trig_cnt + 1'b1;
    end
  end

  // both tones step together
  always_ff @(posedge audio_clk) begin
    if (rst) begin
      phase_a <= '0;
      phase_b <= '0;
    end else if (trig) begin
      phase_a <= phase_a + phase_t'(`PHASE_INCR_750);
      phase_b <= phase_b + phase_t'(`PHASE_INCR_440);
    end
  end

  // one table, read at two phases
  assign tone_a = SINE_LUT[phase_a[LUT_MSB:LUT_LSB]];
  assign tone_b = SINE_LUT[phase_b[LUT_MSB:LUT_LSB]];

endmodule

//--- logic/speaker_drive.sv
`timescale 1ns/1ns

module speaker_drive (
  input  logic                         audio_clk,
  input  logic                         rst,
  input  board_ctrl_pkg::board_ctrl_t  ctrl,
  input  audio_types_pkg::mic_sample_t mic_full,
  input  audio_types_pkg::mic_sample_t mic_decim,
  input  audio_types_pkg::tone_t       tone_a,
  input  audio_types_pkg::tone_t       tone_b,
  output logic                         spk_l,
  output logic                         spk_r,
  output audio_types_pkg::sample_t     level_monitor,
  output audio_types_pkg::mic_sample_t mic_latest
);

  import audio_types_pkg::*;
  import board_ctrl_pkg::*;

  mic_sample_t       held_full;
  sample_t           held_decim;
  tone_t             sel_tone;
  sample_t           tone_ext;
  sample_t           tone_wide;
  sample_t           level_next;
  logic [SAMPLE_W-1:0] level_u;
  logic [SAMPLE_W:0]   pdm_acc;

  // latest microphone words, kept between strobes
  always_ff @(posedge audio_clk) begin
    if (rst) begin
      held_full  <= '0;
      held_decim <= '0;
    end else begin
      if (mic_full.valid) begin
        held_full.valid <= 1'b1;
        held_full.data  <= mic_full.data;
      end
      if (mic_decim.valid) begin
        held_decim <= mic_decim.data;
      end
    end
  end

  assign mic_latest = held_full;

  // 8-bit tone to 16-bit sample
  assign sel_tone = ctrl.tone_750 ? tone_a : tone_b;
  assign tone_ext = sample_t'(sel_tone);
  assign tone_wide = tone_ext <<< 8;

  always_comb begin
    case (ctrl.source)
      SRC_TONE:      level_next = tone_wide;
      SRC_MIC:       level_next = held_full.data;
      SRC_MIC_DECIM: level_next = held_decim;
      SRC_SILENT:    level_next = '0;
      default:       level_next = '0;
    endcase
  end

  always_ff @(posedge audio_clk) begin
    if (rst) begin
      level_monitor <= '0;
    end else begin
      level_monitor <= level_next;
    end
  end

  // offset binary, so -32768 maps to 0 and full scale to 65535
  assign level_u = level_monitor ^ {1'b1, {(SAMPLE_W - 1){1'b0}}};

  // first-order sigma-delta, carry out is the pulse
  always_ff @(posedge audio_clk) begin
    if (rst) begin
      pdm_acc <= '0;
    end else begin
      pdm_acc <= {1'b0, pdm_acc[SAMPLE_W-1:0]} + {1'b0, level_u};
    end
  end

  assign spk_l = ctrl.spk_l_en & pdm_acc[SAMPLE_W];
  assign spk_r = ctrl.spk_r_en & pdm_acc[SAMPLE_W];

endmodule

//--- logic/audio_board_top.sv
`timescale 1ns/1ns

module audio_board_top (
  input  logic                         audio_clk,
  input  logic                         rst,
  input  logic [15:0]                  sw,
  input  logic                         mic_data,
  output logic                         mic_bclk,
  output logic                         mic_ws,
  output logic                         spk_l,
  output logic                         spk_r,
  output audio_types_pkg::sample_t     level_monitor,
  output audio_types_pkg::mic_sample_t mic_latest
);

  import audio_types_pkg::*;
  import board_ctrl_pkg::*;

  board_ctrl_t ctrl;
  mic_sample_t mic_full;
  mic_sample_t mic_decim;
  tone_t       tone_a;
  tone_t       tone_b;

  // switch decode, tone wins over the microphone paths
  always_comb begin
    ctrl.spk_l_en = sw[0];
    ctrl.spk_r_en = sw[1];
    ctrl.tone_750 = sw[2];
    if (sw[3]) begin
      ctrl.source = SRC_TONE;
    end else if (sw[4]) begin
      ctrl.source = SRC_MIC;
    end else if (sw[5]) begin
      ctrl.source = SRC_MIC_DECIM;
    end else begin
      ctrl.source = SRC_SILENT;
    end
  end

  i2s_mic_receiver u_mic (
    .audio_clk (audio_clk),
    .rst       (rst),
    .mic_data  (mic_data),
    .mic_bclk  (mic_bclk),
    .mic_ws    (mic_ws),
    .mic_full  (mic_full),
    .mic_decim (mic_decim)
  );

  tone_source u_tones (
    .audio_clk (audio_clk),
    .rst       (rst),
    .tone_a    (tone_a),
    .tone_b    (tone_b)
  );

  speaker_drive u_spk (
    .audio_clk     (audio_clk),
    .rst           (rst),
    .ctrl          (ctrl),
    .mic_full      (mic_full),
    .mic_decim     (mic_decim),
    .tone_a        (tone_a),
    .tone_b        (tone_b),
    .spk_l         (spk_l),
    .spk_r         (spk_r),
    .level_monitor (level_monitor),
    .mic_latest    (mic_latest)
  );

endmodule

//--- testbench/audio_board_tb.sv
`timescale 1ns/1ns

`include "audio_cfg.svh"

module audio_board_tb;

  import audio_types_pkg::*;

  localparam int RST_CYCLES = 2;
  localparam int FRAME_CYCLES = `I2S_CLK_DIV * 2 * `I2S_SLOT_BITS;
  localparam int NROWS = 8;
  localparam int TIMEOUT_CYCLES = NROWS * 6 * FRAME_CYCLES + 20000;
  localparam int WINDOW = 256;
  localparam int K_MIC = 0;
  localparam int K_DECIM = 1;
  localparam int K_TONE = 2;
  localparam int K_PDM = 3;

  // name, switches and kind of each row with its word or step count
  // spare source bits in some rows exercise the switch priority
  string       row_name [NROWS] = '{"mic_full", "mic_decim", "tone_750", "tone_440",
                                    "pdm_mic", "pdm_silent", "gate_left", "gate_right"};
  logic [15:0] row_sw [NROWS] = '{16'h0033, 16'h0023, 16'h003f, 16'h003b,
                                  16'h0013, 16'h0003, 16'h0002, 16'h0001};
  int          row_kind [NROWS] = '{K_MIC, K_DECIM, K_TONE, K_TONE, K_PDM, K_PDM, K_PDM, K_PDM};
  int          row_len [NROWS] = '{4, 4, 8, 8, 1, 0, 0, 0};

  logic        audio_clk = 1'b0;
  logic        rst;
  logic [15:0] sw;
  logic        mic_data;
  logic        mic_bclk;
  logic        mic_ws;
  logic        spk_l;
  logic        spk_r;
  sample_t     level_monitor;
  mic_sample_t mic_latest;

  sample_t     word_q [$];
  sample_t     exp_full = '0;
  sample_t     exp_decim = '0;
  int          cyc = 0;
  int          sample_errs = 0;
  int          mic_errs = 0;
  int          count_errs = 0;

  audio_board_top DUT (.*);

  always begin
    #10;
    audio_clk = ~audio_clk;
  end

  // watchdog sized from the table length
  always @(posedge audio_clk) begin
    cyc <= cyc + 1;
    if (cyc >= TIMEOUT_CYCLES) begin
      $display("timeout after %0d cycles, the DUT never produced the awaited edge", cyc);
      $display("TEST FAIL");
      $finish;
    end
  end

  // i2s microphone model that starts a frame at reset release and on each fall of mic_ws
  initial begin
    sample_t word;
    int      sent;
    int      pos;
    logic    prev_ws;
    mic_data = 1'b0;
    word = '0;
    sent = 0;
    pos = 0;
    prev_ws = 1'b0;
    @(negedge rst);
    forever begin
      if (pos == 0) begin
        word = (word_q.size() > 0) ? word_q.pop_front() : '0;
        sent = sent + 1;
        exp_full = word;
        // words two, four and on reach the decimated stream
        if (sent % 2 == 0) begin
          exp_decim = word;
        end
      end
      @(negedge mic_bclk);
      #2;
      pos = (prev_ws && !mic_ws) ? 0 : pos + 1;
      prev_ws = mic_ws;
      // one delay bit and 16 bits MSB first with zeros after
      mic_data = (pos >= 1 && pos <= SAMPLE_W) ? word[4'(SAMPLE_W - pos)] : 1'b0;
    end
  end

  task automatic check_sample(string name, sample_t expected, sample_t actual);
    if (actual !== expected) begin
      sample_errs++;
      $display("ERR %s expected %0d actual %0d", name, expected, actual);
    end
  endtask

  task automatic check_mic(string name, mic_sample_t expected, mic_sample_t actual);
    if (actual !== expected) begin
      mic_errs++;
      $display("ERR %s expected %h actual %h", name, expected, actual);
    end
  endtask

  task automatic check_bit_count(string name, int lo, int hi, int actual);
    if (actual < lo || actual > hi) begin
      count_errs++;
      $display("ERR %s expected %0d to %0d actual %0d", name, lo, hi, actual);
    end
  endtask

  // ones in the window lie within 1 of 256 * (L + 32768) / 65536
  task automatic check_density(string name, sample_t level, logic en, int ones);
    int scaled;
    scaled = WINDOW * (int'(level) + 32768);
    if (en) begin
      check_bit_count(name, (scaled + 65535) / 65536 - 1, (scaled + 65536) / 65536, ones);
    end else begin
      check_bit_count(name, 0, 0, ones);
    end
  endtask

  // sine of the top six phase bits after n steps widened by 8
  function automatic sample_t tone_level(int step, logic sel_750);
    logic [31:0] phase;
    real         amp;
    phase = 32'(step) * (sel_750 ? `PHASE_INCR_750 : `PHASE_INCR_440);
    amp = 127.0 * $sin(2.0 * 3.141592653589793 * real'(phase[31:26]) / 64.0);
    amp = (amp >= 0.0) ? amp + 0.5 : amp - 0.5;
    return sample_t'($rtoi(amp) * 256);
  endfunction

  // left slot is complete once the word clock rises
  task automatic frame_done();
    @(posedge mic_ws);
    @(negedge audio_clk);
  endtask

  initial begin
    int          ones_l;
    int          ones_r;
    int          step;
    sample_t     level;
    mic_sample_t want;
    rst = 1'b1;
    sw = 16'h0003;
    void'($urandom(32'h30ba_2619));
    repeat (RST_CYCLES) @(posedge audio_clk);
    #2;
    rst = 1'b0;
    @(negedge audio_clk);
    check_sample("reset_level", '0, level_monitor);
    check_mic("reset_mic", '0, mic_latest);
    check_bit_count("reset_pins", 0, 0,
                    int'(spk_l) + int'(spk_r) + int'(mic_bclk) + int'(mic_ws));

    for (int r = 0; r < NROWS; r++) begin
      @(posedge audio_clk);
      #2;
      sw = row_sw[r];
      if (row_kind[r] == K_TONE) begin
        // first step lands TONE_TRIG_DIV cycles after reset release
        step = (cyc - RST_CYCLES) / `TONE_TRIG_DIV + 1;
        repeat (row_len[r]) begin
          while (cyc < RST_CYCLES + step * `TONE_TRIG_DIV + 4) begin
            @(negedge audio_clk);
          end
          check_sample(row_name[r], tone_level(step, row_sw[r][2]), level_monitor);
          step++;
        end
      end else begin
        level = '0;
        if (row_len[r] > 0) begin
          frame_done();
        end
        repeat (row_len[r]) begin
          word_q.push_back(sample_t'($urandom()));
          frame_done();
          want.valid = 1'b1;
          want.data = exp_full;
          level = (row_kind[r] == K_DECIM) ? exp_decim : exp_full;
          check_sample(row_name[r], level, level_monitor);
          if (row_kind[r] == K_MIC) begin
            check_mic(row_name[r], want, mic_latest);
          end
        end
        if (row_kind[r] == K_PDM) begin
          repeat (4) @(negedge audio_clk);
          check_sample(row_name[r], level, level_monitor);
          ones_l = 0;
          ones_r = 0;
          repeat (WINDOW) begin
            @(negedge audio_clk);
            ones_l += int'(spk_l);
            ones_r += int'(spk_r);
          end
          check_density({row_name[r], "_l"}, level, row_sw[r][0], ones_l);
          check_density({row_name[r], "_r"}, level, row_sw[r][1], ones_r);
        end
      end
    end

    $display("errors: sample %0d, mic %0d, bit count %0d", sample_errs, mic_errs, count_errs);
    if (sample_errs + mic_errs + count_errs == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

//--- tb.f
+incdir+logic
logic/audio_types_pkg.sv
logic/board_ctrl_pkg.sv
logic/i2s_mic_receiver.sv
logic/tone_source.sv
logic/speaker_drive.sv
logic/audio_board_top.sv
testbench/audio_board_tb.sv

//--- Makefile
VERILATOR  ?= verilator
TB_TOP     ?= audio_board_tb
RTL_TOP    ?= audio_board_top
FILELIST   ?= tb.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing -j 0
LINT_FLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASS"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
